/* filelist.f */
verilog/fmul_pkg.sv
verilog/fmul_exp_if.sv
verilog/fmul_pipe_ctrl.sv
verilog/fmul_exp_path.sv
verilog/fmul_sig_mult.sv
verilog/fmul_round.sv
verilog/fmul_pipe.sv
testbench/tb_fmul_pipe.sv

/* run_sim.sh */
#!/bin/sh
# build and run the multiplier testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
  --top-module tb_fmul_pipe --Mdir obj_dir -o tb_fmul_pipe
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/tb_fmul_pipe 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Result: PASSED"; then
  exit 0
fi
exit 1

/* testbench/tb_fmul_pipe.sv */
// ------------------------------
// random mix of normals, specials, subnormals
// and range-limit pairs, fixed LCG seed
// expects RNE with flush to signed zero
// ------------------------------
`timescale 1ns/10ps

module tb_fmul_pipe import fmul_pkg::*; ();

  localparam int CLK_PERIOD = 20;
  localparam int N_RANDOM   = 1200;
  localparam int N_FAST     = 300;
  localparam int TIMEOUT_NS = 20 * (N_RANDOM + N_FAST) * CLK_PERIOD;

  logic clk = 1'b0, rst_n, in_valid_i, out_ready_i, in_ready_o, out_valid_o;
  word_t a_i, b_i, result_o, held_result;
  tag_t tag_i, tag_o, held_tag;
  fflags_t flags_o, held_flags;
  int unsigned lcg_state = 69;
  int cycle = 0, issued = 0, accepted = 0, retired = 0;
  bit fast_phase = 1'b0, hold_pending = 1'b0;
  word_t exp_word_q[$];
  fflags_t exp_flags_q[$];
  tag_t exp_tag_q[$];
  int acc_cycle_q[$];
  bit lat_check_q[$];

  fmul_pipe fmul_pipe_inst (.*);

  initial begin
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  function automatic int unsigned next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 8;
  endfunction

  function automatic word_t normal_with_exp(input int unsigned e);
    return {1'(next_rand()), 8'(e), 23'(next_rand())};
  endfunction

  function automatic word_t pick_operand();
    int unsigned r;
    logic sgn;
    r = next_rand() % 16;
    sgn = 1'(next_rand());
    case (r)
      9: return {sgn, 8'(1 + next_rand() % 254), 23'(next_rand()) & 23'h7F_F000};
      10: return {sgn, 31'h0};
      11: return {sgn, 8'hFF, 23'h0};
      12: return {sgn, 8'hFF, 1'b1, 22'(next_rand())};
      13: return {sgn, 8'hFF, 1'b0, 22'(next_rand() | 1)};
      14, 15: return {sgn, 8'h00, 23'(next_rand() | 1)};
      default: return normal_with_exp(1 + next_rand() % 254);
    endcase
  endfunction

  // near overflow the exponents sum to about 255, near underflow to about 0
  task automatic make_pair(output word_t a, output word_t b);
    int unsigned r;
    r = next_rand() % 10;
    if (r < 6) begin
      a = pick_operand();
      b = pick_operand();
    end else if (r < 8) begin
      a = normal_with_exp(180 + next_rand() % 20);
      b = normal_with_exp(190 + next_rand() % 20);
    end else begin
      a = normal_with_exp(40 + next_rand() % 30);
      b = normal_with_exp(50 + next_rand() % 30);
    end
  endtask

  function automatic void ref_fmul(input word_t a, input word_t b,
                                   output word_t res, output fflags_t fl);
    int ea, eb, e;
    logic s, a_nan, b_nan, a_inf, b_inf, a_zero, b_zero, inf_zero, snan, g, st;
    logic [47:0] p;
    logic [24:0] m;
    ea = int'(a[30:23]);
    eb = int'(b[30:23]);
    s = a[31] ^ b[31];
    a_nan = (ea == 255) && (a[22:0] != 0);
    b_nan = (eb == 255) && (b[22:0] != 0);
    a_inf = (ea == 255) && (a[22:0] == 0);
    b_inf = (eb == 255) && (b[22:0] == 0);
    a_zero = (ea == 0);
    b_zero = (eb == 0);
    inf_zero = (a_inf && b_zero) || (b_inf && a_zero);
    snan = (a_nan && !a[22]) || (b_nan && !b[22]);
    fl = 4'b0000;
    if (a_nan || b_nan || inf_zero) begin
      res = QNAN;
      fl = {snan || inf_zero, 3'b000};
    end else if (a_inf || b_inf) begin
      res = {s, 8'hFF, 23'h0};
    end else if (a_zero || b_zero) begin
      res = {s, 31'h0};
    end else begin
      p = 48'({1'b1, a[22:0]}) * 48'({1'b1, b[22:0]});
      e = ea + eb - EXP_BIAS;
      if (p[47]) begin
        m = {1'b0, p[47:24]};
        g = p[23];
        st = |p[22:0];
        e = e + 1;
      end else begin
        m = {1'b0, p[46:23]};
        g = p[22];
        st = |p[21:0];
      end
      if (g && (st || m[0])) m = m + 25'd1;
      if (m[24]) begin
        m = m >> 1;
        e = e + 1;
      end
      if (e >= 255) begin
        res = {s, 8'hFF, 23'h0};
        fl = 4'b0101;
      end else if (e <= 0) begin
        res = {s, 31'h0};
        fl = 4'b0011;
      end else begin
        res = {s, 8'(e), m[22:0]};
        fl = {3'b000, g || st};
      end
    end
  endfunction

  task automatic abort_run();
    $display("Result: FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      $display("** Error: %s expected %h got %h", name, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_flags(input string name, input fflags_t expected,
                             input fflags_t actual);
    if (actual !== expected) begin
      $display("** Error: %s expected %h got %h", name, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_tag(input string name, input tag_t expected, input tag_t actual);
    if (actual !== expected) begin
      $display("** Error: %s expected %h got %h", name, expected, actual);
      abort_run();
    end
  endtask

  // sampled on the falling edge so the values match the next rising edge
  always @(negedge clk) begin
    word_t w;
    fflags_t f;
    int lat;
    if (rst_n) begin
      if (in_valid_i && in_ready_o) begin
        ref_fmul(a_i, b_i, w, f);
        exp_word_q.push_back(w);
        exp_flags_q.push_back(f);
        exp_tag_q.push_back(tag_i);
        acc_cycle_q.push_back(cycle);
        lat_check_q.push_back(fast_phase);
        accepted++;
      end
      if (fast_phase && !in_ready_o) begin
        $display("in_ready_o dropped while out_ready_i was held high");
        abort_run();
      end
      if (hold_pending) begin
        if (!out_valid_o) begin
          $display("out_valid_o dropped while the output was stalled");
          abort_run();
        end
        check_word("result_o", held_result, result_o);
        check_flags("flags_o", held_flags, flags_o);
        check_tag("tag_o", held_tag, tag_o);
      end
      if (out_valid_o && out_ready_i) begin
        if (exp_word_q.size() == 0) begin
          $display("an output came out with no accepted input left to match");
          abort_run();
        end
        check_word("result_o", exp_word_q.pop_front(), result_o);
        check_flags("flags_o", exp_flags_q.pop_front(), flags_o);
        check_tag("tag_o", exp_tag_q.pop_front(), tag_o);
        lat = cycle - acc_cycle_q.pop_front();
        if (lat_check_q.pop_front() && lat != 2) begin
          $display("item came out %0d cycles after acceptance instead of 2", lat);
          abort_run();
        end
        retired++;
      end
      hold_pending = out_valid_o && !out_ready_i;
      held_result = result_o;
      held_flags = flags_o;
      held_tag = tag_o;
    end
  end

  // an item stays on the inputs until it is taken
  task automatic run_phase(input int n_items, input bit random_ready);
    int goal;
    goal = issued + n_items;
    while (accepted < goal) begin
      @(posedge clk);
      #2;
      out_ready_i = random_ready ? ((next_rand() % 3) != 0) : 1'b1;
      if (!in_valid_i || accepted == issued) begin
        if (issued < goal && (!random_ready || (next_rand() % 4) != 0)) begin
          make_pair(a_i, b_i);
          tag_i = tag_t'(next_rand());
          in_valid_i = 1'b1;
          issued++;
        end else begin
          in_valid_i = 1'b0;
        end
      end
    end
  endtask

  initial begin
    rst_n = 1'b0;
    in_valid_i = 1'b0;
    out_ready_i = 1'b0;
    a_i = '0;
    b_i = '0;
    tag_i = '0;
    repeat (16) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(negedge clk);
    if (out_valid_o !== 1'b0 || in_ready_o !== 1'b1) begin
      $display("after reset out_valid_o should be low and in_ready_o high");
      abort_run();
    end
    run_phase(N_RANDOM, 1'b1);
    @(posedge clk);
    #2;
    out_ready_i = 1'b1;
    fast_phase = 1'b1;
    run_phase(N_FAST, 1'b0);
    wait (retired == accepted);
    repeat (2) @(posedge clk);
    #2;
    // the drained pipe must not present a further item
    if (out_valid_o === 1'b0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      $display("out_valid_o still high after every accepted item came out");
      abort_run();
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("watchdog expired before all items came out of the pipe");
    abort_run();
  end

endmodule

/* verilog/fmul_exp_if.sv */
// ------------------------------
// exponent path to rounding stage
// all fields change together on en1
// ------------------------------
`timescale 1ns/10ps

interface fmul_exp_if import fmul_pkg::*;;

  logic     sign;
  exp_sum_t exp_sum;
  special_e kind;
  // inf times zero or a signaling NaN operand
  logic     invalid;
  tag_t     tag;

  modport src (
    output sign, exp_sum, kind, invalid, tag
  );

  modport dst (
    input sign, exp_sum, kind, invalid, tag
  );

endinterface

/* verilog/fmul_exp_path.sv */
// ------------------------------
// sign, exponent sum and special cases
// zero exponent field counts as zero, so
// subnormal operands act as signed zero
// ------------------------------
`timescale 1ns/10ps

module fmul_exp_path import fmul_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       en1_i,
  input  word_t      a_i,
  input  word_t      b_i,
  input  tag_t       tag_i,
  fmul_exp_if.src    exp_o
);

  logic [EXP_W-1:0] a_exp;
  logic [EXP_W-1:0] b_exp;
  logic             a_zero, a_inf, a_nan, a_snan;
  logic             b_zero, b_inf, b_nan, b_snan;
  logic             inf_times_zero;
  special_e         kind_d;
  exp_sum_t         exp_sum_d;

  assign a_exp = a_i[EXP_W+SIG_W-2:SIG_W-1];
  assign b_exp = b_i[EXP_W+SIG_W-2:SIG_W-1];

  assign a_zero = (a_exp == '0);
  assign b_zero = (b_exp == '0);
  assign a_inf  = (a_exp == '1) && (a_i[SIG_W-2:0] == '0);
  assign b_inf  = (b_exp == '1) && (b_i[SIG_W-2:0] == '0);
  assign a_nan  = (a_exp == '1) && (a_i[SIG_W-2:0] != '0);
  assign b_nan  = (b_exp == '1) && (b_i[SIG_W-2:0] != '0);
  // quiet bit clear
  assign a_snan = a_nan && !a_i[SIG_W-2];
  assign b_snan = b_nan && !b_i[SIG_W-2];

  assign inf_times_zero = (a_inf && b_zero) || (a_zero && b_inf);

  // NaN first, then inf*0, then inf, then zero
  always_comb begin
    if (a_nan || b_nan || inf_times_zero) begin
      kind_d = SPC_NAN;
    end else if (a_inf || b_inf) begin
      kind_d = SPC_INF;
    end else if (a_zero || b_zero) begin
      kind_d = SPC_ZERO;
    end else begin
      kind_d = SPC_NONE;
    end
  end

  assign exp_sum_d = exp_sum_t'({2'b00, a_exp}) + exp_sum_t'({2'b00, b_exp})
                   - exp_sum_t'(EXP_BIAS);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exp_o.kind    <= SPC_NONE;
      exp_o.invalid <= 1'b0;
    end else if (en1_i) begin
      exp_o.kind    <= kind_d;
      exp_o.invalid <= a_snan || b_snan || inf_times_zero;
    end
  end

  always_ff @(posedge clk) begin
    if (en1_i) begin
      exp_o.sign    <= a_i[EXP_W+SIG_W-1] ^ b_i[EXP_W+SIG_W-1];
      exp_o.exp_sum <= exp_sum_d;
      exp_o.tag     <= tag_i;
    end
  end

endmodule

/* verilog/fmul_pipe.sv */
// ------------------------------
// two-stage binary32 multiplier
// round to nearest even only, 2 cycle
// latency, tag follows each item
// ------------------------------
`timescale 1ns/10ps

module fmul_pipe import fmul_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    in_valid_i,
  input  logic    out_ready_i,
  input  word_t   a_i,
  input  word_t   b_i,
  input  tag_t    tag_i,
  output logic    in_ready_o,
  output logic    out_valid_o,
  output word_t   result_o,
  output fflags_t flags_o,
  output tag_t    tag_o
);

  logic  en1;
  logic  en2;
  prod_t prod;

  fmul_exp_if exp_bus ();

  fmul_pipe_ctrl u_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid_i (in_valid_i),
    .out_ready_i(out_ready_i),
    .in_ready_o (in_ready_o),
    .out_valid_o(out_valid_o),
    .en1_o      (en1),
    .en2_o      (en2)
  );

  // stage 1, both paths in parallel
  fmul_exp_path u_exp_path (
    .clk  (clk),
    .rst_n(rst_n),
    .en1_i(en1),
    .a_i  (a_i),
    .b_i  (b_i),
    .tag_i(tag_i),
    .exp_o(exp_bus.src)
  );

  fmul_sig_mult u_sig_mult (
    .clk   (clk),
    .rst_n (rst_n),
    .en1_i (en1),
    .a_i   (a_i),
    .b_i   (b_i),
    .prod_o(prod)
  );

  // stage 2
  fmul_round u_round (
    .clk     (clk),
    .rst_n   (rst_n),
    .en2_i   (en2),
    .exp_i   (exp_bus.dst),
    .prod_i  (prod),
    .result_o(result_o),
    .flags_o (flags_o),
    .tag_o   (tag_o)
  );

endmodule

/* verilog/fmul_pipe_ctrl.sv */
// ------------------------------
// valid/ready control for a two-stage pipe
// one item per cycle, ready drops only when
// both stages hold data and the sink stalls
// ------------------------------
`timescale 1ns/10ps

module fmul_pipe_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic in_valid_i,
  input  logic out_ready_i,
  output logic in_ready_o,
  output logic out_valid_o,
  output logic en1_o,
  output logic en2_o
);

  logic v1_q;
  logic v2_q;
  logic adv1;
  logic adv2;

  // stage 2 moves when empty or its item leaves
  assign adv2 = !v2_q || out_ready_i;
  assign adv1 = !v1_q || adv2;

  assign in_ready_o  = adv1;
  assign out_valid_o = v2_q;
  assign en1_o       = in_valid_i && adv1;
  assign en2_o       = v1_q && adv2;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      v1_q <= 1'b0;
      v2_q <= 1'b0;
    end else begin
      if (adv1) begin
        v1_q <= in_valid_i;
      end
      if (adv2) begin
        v2_q <= v1_q;
      end
    end
  end

  // a stalled output item is never dropped
  assert property (@(posedge clk) disable iff (!rst_n)
    out_valid_o && !out_ready_i |=> out_valid_o);

  // a stage 1 item that cannot move on stays in place
  assert property (@(posedge clk) disable iff (!rst_n)
    v1_q && !en2_o |=> v1_q);

endmodule

/* verilog/fmul_pkg.sv */
// ------------------------------
// binary32 multiplier definitions
// subnormals are not represented, the
// datapath reads them as signed zero
// flag order is invalid, overflow, underflow, inexact
// ------------------------------
package fmul_pkg;

  // binary32 format
  localparam int EXP_W    = 8;
  localparam int SIG_W    = 24;
  localparam int EXP_BIAS = 127;
  localparam int EXP_MAX  = 255;

  // register-index tag width
  localparam int TAG_W    = 8;

  typedef logic [EXP_W+SIG_W-1:0] word_t;

  // significand with hidden bit
  typedef logic [SIG_W-1:0] sig_t;

  // raw product of two significands
  typedef logic [2*SIG_W-1:0] prod_t;

  // biased exponent sum with two extra bits for overflow and underflow
  typedef logic signed [EXP_W+1:0] exp_sum_t;

  typedef logic [TAG_W-1:0] tag_t;

  // {invalid, overflow, underflow, inexact}
  typedef logic [3:0] fflags_t;

  // operand pair classification
  typedef enum logic [1:0] {
    SPC_NONE = 2'd0,
    SPC_ZERO = 2'd1,
    SPC_INF  = 2'd2,
    SPC_NAN  = 2'd3
  } special_e;

  // canonical quiet NaN
  localparam word_t QNAN = 32'h7FC0_0000;

endpackage

/* verilog/fmul_round.sv */
// ------------------------------
// normalize and round to nearest even
// tiny results flush to signed zero,
// large ones saturate to signed infinity
// ------------------------------
`timescale 1ns/10ps

module fmul_round import fmul_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    en2_i,
  fmul_exp_if.dst exp_i,
  input  prod_t   prod_i,
  output word_t   result_o,
  output fflags_t flags_o,
  output tag_t    tag_o
);

  logic [SIG_W-2:0] frac_norm;
  logic             guard_bit;
  logic             sticky_bit;
  logic             round_up;
  logic [SIG_W-1:0] frac_rnd;
  logic             inexact;
  exp_sum_t         exp_norm;
  exp_sum_t         exp_fin;
  word_t            result_d;
  fflags_t          flags_d;

  // product of two normals lies in [1,4)
  always_comb begin
    if (prod_i[2*SIG_W-1]) begin
      frac_norm  = prod_i[2*SIG_W-2:SIG_W];
      guard_bit  = prod_i[SIG_W-1];
      sticky_bit = |prod_i[SIG_W-2:0];
      exp_norm   = exp_i.exp_sum + exp_sum_t'(1);
    end else begin
      frac_norm  = prod_i[2*SIG_W-3:SIG_W-1];
      guard_bit  = prod_i[SIG_W-2];
      sticky_bit = |prod_i[SIG_W-3:0];
      exp_norm   = exp_i.exp_sum;
    end
  end

  // ties go to the even fraction
  assign round_up = guard_bit && (sticky_bit || frac_norm[0]);
  assign frac_rnd = {1'b0, frac_norm} + {{(SIG_W-1){1'b0}}, round_up};
  // carry out means an all-ones fraction rolled over to 2.0
  assign exp_fin  = exp_norm + exp_sum_t'(frac_rnd[SIG_W-1]);
  assign inexact  = guard_bit || sticky_bit;

  always_comb begin
    result_d = {exp_i.sign, exp_fin[EXP_W-1:0], frac_rnd[SIG_W-2:0]};
    flags_d  = {3'b000, inexact};
    case (exp_i.kind)
      SPC_NAN: begin
        result_d = QNAN;
        flags_d  = {exp_i.invalid, 3'b000};
      end
      SPC_INF: begin
        result_d = {exp_i.sign, EXP_W'(EXP_MAX), {(SIG_W-1){1'b0}}};
        flags_d  = '0;
      end
      SPC_ZERO: begin
        result_d = {exp_i.sign, {(EXP_W+SIG_W-1){1'b0}}};
        flags_d  = '0;
      end
      default: begin
        if (exp_fin >= EXP_MAX) begin
          result_d = {exp_i.sign, EXP_W'(EXP_MAX), {(SIG_W-1){1'b0}}};
          flags_d  = 4'b0101;
        end else if (exp_fin <= 0) begin
          result_d = {exp_i.sign, {(EXP_W+SIG_W-1){1'b0}}};
          flags_d  = 4'b0011;
        end
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flags_o <= '0;
    end else if (en2_i) begin
      flags_o <= flags_d;
    end
  end

  always_ff @(posedge clk) begin
    if (en2_i) begin
      result_o <= result_d;
      tag_o    <= exp_i.tag;
    end
  end

  // no subnormal encoding ever leaves the stage
  assert property (@(posedge clk) disable iff (!rst_n)
    en2_i |=> (result_o[EXP_W+SIG_W-2:SIG_W-1] != '0) || (result_o[SIG_W-2:0] == '0));

endmodule

/* verilog/fmul_sig_mult.sv */
// ------------------------------
// 24x24 significand product, one cycle
// hidden bit is zero for a zero exponent
// ------------------------------
`timescale 1ns/10ps

module fmul_sig_mult import fmul_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  en1_i,
  input  word_t a_i,
  input  word_t b_i,
  output prod_t prod_o
);

  sig_t a_sig;
  sig_t b_sig;

  // restore the hidden one
  assign a_sig = {|a_i[EXP_W+SIG_W-2:SIG_W-1], a_i[SIG_W-2:0]};
  assign b_sig = {|b_i[EXP_W+SIG_W-2:SIG_W-1], b_i[SIG_W-2:0]};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prod_o <= '0;
    end else if (en1_i) begin
      prod_o <= prod_t'(a_sig) * prod_t'(b_sig);
    end
  end

endmodule
